// File: rtl/rvIsaPkg.sv
// ------------------------------------------------
// RV32I subset encodings and field widths
// Only the codes the core decodes are defined
// ------------------------------------------------
package rvIsaPkg;

    localparam int XLEN       = 32;  // Data and address width
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;
    localparam int SHAMT_W    = 5;   // Shift amount taken from operand B

    // Major opcodes
    localparam logic [OPCODE_W-1:0] OP_RTYPE  = 7'b0110011;
    localparam logic [OPCODE_W-1:0] OP_ITYPE  = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OP_LOAD   = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OP_STORE  = 7'b0100011;
    localparam logic [OPCODE_W-1:0] OP_BRANCH = 7'b1100011;
    localparam logic [OPCODE_W-1:0] OP_JAL    = 7'b1101111;
    localparam logic [OPCODE_W-1:0] OP_LUI    = 7'b0110111;

    // Arithmetic funct3
    localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_SLL     = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_SLT     = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_SLTU    = 3'b011;
    localparam logic [FUNCT3_W-1:0] F3_XOR     = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_SR      = 3'b101;  // SRL or SRA
    localparam logic [FUNCT3_W-1:0] F3_OR      = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND     = 3'b111;

    // Branch funct3
    localparam logic [FUNCT3_W-1:0] F3_BEQ  = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_BNE  = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_BLT  = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_BGE  = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_BLTU = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_BGEU = 3'b111;

    localparam logic [FUNCT7_W-1:0] F7_ALT = 7'b0100000;  // SUB and SRA

    localparam logic [XLEN-1:0] RESET_PC = '0;

endpackage

// File: rtl/rvCtrlPkg.sv
// ------------------------------------------------
// Datapath control encodings shared by the
// control unit, ALU and register file
// ------------------------------------------------
package rvCtrlPkg;

    // ALU operation, PASSB forwards operand B for LUI
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASSB
    } aluOpT;

    // Register writeback source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4   // Link value for JAL
    } wbSelT;

    // ALU operand B source
    typedef enum logic {
        OPB_REG,
        OPB_IMM
    } opBSelT;

endpackage

// File: rtl/instDecoder.sv
// ------------------------------------------------
// Field extraction, immediate is zero for R-type
// and for unknown opcodes
// ------------------------------------------------
`timescale 1ns/1ps

module instDecoder (
    input  logic [rvIsaPkg::XLEN-1:0]       i_inst,
    output logic [rvIsaPkg::REG_ADDR_W-1:0] o_rs1,
    output logic [rvIsaPkg::REG_ADDR_W-1:0] o_rs2,
    output logic [rvIsaPkg::REG_ADDR_W-1:0] o_rd,
    output logic [rvIsaPkg::FUNCT3_W-1:0]   o_funct3,
    output logic [rvIsaPkg::XLEN-1:0]       o_imm
);

    logic [rvIsaPkg::OPCODE_W-1:0] opcode;
    logic [rvIsaPkg::XLEN-1:0]     immI;
    logic [rvIsaPkg::XLEN-1:0]     immS;
    logic [rvIsaPkg::XLEN-1:0]     immB;
    logic [rvIsaPkg::XLEN-1:0]     immJ;
    logic [rvIsaPkg::XLEN-1:0]     immU;

    // Fixed field positions in every format
    assign opcode   = i_inst[6:0];
    assign o_rd     = i_inst[11:7];
    assign o_funct3 = i_inst[14:12];
    assign o_rs1    = i_inst[19:15];
    assign o_rs2    = i_inst[24:20];

    // Sign bit is always inst[31]
    assign immI = {{20{i_inst[31]}}, i_inst[31:20]};
    assign immS = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign immB = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                   i_inst[11:8], 1'b0};
    assign immJ = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                   i_inst[30:21], 1'b0};
    assign immU = {i_inst[31:12], 12'b0};

    always_comb begin
        case (opcode)
            rvIsaPkg::OP_ITYPE,
            rvIsaPkg::OP_LOAD:   o_imm = immI;
            rvIsaPkg::OP_STORE:  o_imm = immS;
            rvIsaPkg::OP_BRANCH: o_imm = immB;
            rvIsaPkg::OP_JAL:    o_imm = immJ;
            rvIsaPkg::OP_LUI:    o_imm = immU;
            default:             o_imm = '0;
        endcase
    end

endmodule

// File: rtl/controlUnit.sv
// ------------------------------------------------
// Control decode for the supported RV32I subset
// Unsupported opcodes execute as a no-op
// ------------------------------------------------
`timescale 1ns/1ps

module controlUnit (
    input  logic                      i_rstN,
    input  logic [rvIsaPkg::XLEN-1:0] i_inst,
    output rvCtrlPkg::aluOpT          o_aluOp,
    output rvCtrlPkg::opBSelT         o_opBSel,
    output rvCtrlPkg::wbSelT          o_wbSel,
    output logic                      o_regWrEnable,
    output logic                      o_memWrEnable,
    output logic                      o_isBranch,
    output logic                      o_isJump
);

    logic [rvIsaPkg::OPCODE_W-1:0] opcode;
    logic [rvIsaPkg::FUNCT3_W-1:0] funct3;
    logic [rvIsaPkg::FUNCT7_W-1:0] funct7;
    logic                          useAlt;   // SUB or SRA
    logic                          opKnown;
    logic                          regWr;
    logic                          memWr;
    rvCtrlPkg::aluOpT              arithOp;

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];

    // ADDI has no SUB form, so funct7 only counts for R-type and shifts right
    assign useAlt = (funct7 == rvIsaPkg::F7_ALT) &&
                    ((opcode == rvIsaPkg::OP_RTYPE) || (funct3 == rvIsaPkg::F3_SR));

    always_comb begin
        case (funct3)
            rvIsaPkg::F3_ADD_SUB: arithOp = useAlt ? rvCtrlPkg::ALU_SUB : rvCtrlPkg::ALU_ADD;
            rvIsaPkg::F3_SLL:     arithOp = rvCtrlPkg::ALU_SLL;
            rvIsaPkg::F3_SLT:     arithOp = rvCtrlPkg::ALU_SLT;
            rvIsaPkg::F3_SLTU:    arithOp = rvCtrlPkg::ALU_SLTU;
            rvIsaPkg::F3_XOR:     arithOp = rvCtrlPkg::ALU_XOR;
            rvIsaPkg::F3_SR:      arithOp = useAlt ? rvCtrlPkg::ALU_SRA : rvCtrlPkg::ALU_SRL;
            rvIsaPkg::F3_OR:      arithOp = rvCtrlPkg::ALU_OR;
            default:              arithOp = rvCtrlPkg::ALU_AND;
        endcase
    end

    always_comb begin
        o_aluOp    = rvCtrlPkg::ALU_ADD;  // Address add for loads and stores
        o_opBSel   = rvCtrlPkg::OPB_IMM;
        o_wbSel    = rvCtrlPkg::WB_ALU;
        regWr      = 1'b0;
        memWr      = 1'b0;
        o_isBranch = 1'b0;
        o_isJump   = 1'b0;
        opKnown    = 1'b1;
        case (opcode)
            rvIsaPkg::OP_RTYPE: begin
                o_aluOp  = arithOp;
                o_opBSel = rvCtrlPkg::OPB_REG;
                regWr    = 1'b1;
            end
            rvIsaPkg::OP_ITYPE: begin
                o_aluOp = arithOp;
                regWr   = 1'b1;
            end
            rvIsaPkg::OP_LOAD: begin
                o_wbSel = rvCtrlPkg::WB_MEM;
                regWr   = 1'b1;
            end
            rvIsaPkg::OP_STORE:  memWr = 1'b1;
            rvIsaPkg::OP_BRANCH: o_isBranch = 1'b1;  // Compare is done outside the ALU
            rvIsaPkg::OP_JAL: begin
                o_wbSel  = rvCtrlPkg::WB_PC4;
                regWr    = 1'b1;
                o_isJump = 1'b1;
            end
            rvIsaPkg::OP_LUI: begin
                o_aluOp = rvCtrlPkg::ALU_PASSB;
                regWr   = 1'b1;
            end
            default: opKnown = 1'b0;
        endcase
    end

    // No architectural writes while in reset
    assign o_regWrEnable = regWr && i_rstN;
    assign o_memWrEnable = memWr && i_rstN;

    // Only the listed opcodes are expected out of reset
    knownOpcode: assert final (!i_rstN || opKnown)
        else $error("Unsupported opcode %b", opcode);

    // R-type funct7 is zero except for SUB and SRA
    legalFunct7: assert final (!i_rstN || (opcode != rvIsaPkg::OP_RTYPE) || (funct7 == '0) ||
                               ((funct7 == rvIsaPkg::F7_ALT) &&
                                ((funct3 == rvIsaPkg::F3_ADD_SUB) ||
                                 (funct3 == rvIsaPkg::F3_SR))))
        else $error("Unsupported R-type funct7 %b, inst %h", funct7, i_inst);

endmodule

// File: rtl/regFile.sv
// ------------------------------------------------
// 32x32 registers, x0 writes are dropped
// Reads are combinational, writes at the edge
// ------------------------------------------------
`timescale 1ns/1ps

module regFile (
    input  logic                            i_Clock,
    input  logic                            i_rstN,
    input  logic [rvIsaPkg::REG_ADDR_W-1:0] i_rdAddrA,
    input  logic [rvIsaPkg::REG_ADDR_W-1:0] i_rdAddrB,
    input  logic [rvIsaPkg::REG_ADDR_W-1:0] i_wrAddr,
    input  logic                            i_wrEnable,
    input  rvCtrlPkg::wbSelT                i_wbSel,
    input  logic [rvIsaPkg::XLEN-1:0]       i_aluResult,
    input  logic [rvIsaPkg::XLEN-1:0]       i_memRdData,
    input  logic [rvIsaPkg::XLEN-1:0]       i_pcPlus4,
    output logic [rvIsaPkg::XLEN-1:0]       o_rdDataA,
    output logic [rvIsaPkg::XLEN-1:0]       o_rdDataB
);

    logic [rvIsaPkg::XLEN-1:0] regs [2**rvIsaPkg::REG_ADDR_W];
    logic [rvIsaPkg::XLEN-1:0] wrData;

    // Writeback source
    always_comb begin
        case (i_wbSel)
            rvCtrlPkg::WB_MEM: wrData = i_memRdData;
            rvCtrlPkg::WB_PC4: wrData = i_pcPlus4;
            default:           wrData = i_aluResult;
        endcase
    end

    always_ff @(posedge i_Clock) begin
        if (!i_rstN) begin
            for (int i = 0; i < 2**rvIsaPkg::REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wrEnable && (i_wrAddr != '0)) begin
            regs[i_wrAddr] <= wrData;
        end
    end

    assign o_rdDataA = regs[i_rdAddrA];
    assign o_rdDataB = regs[i_rdAddrB];

    // Unknown bits never reach architectural state
    wrDataKnown: assert property (@(posedge i_Clock) disable iff (!i_rstN)
            i_wrEnable && (i_wrAddr != '0) |-> !$isunknown(wrData))
        else $error("Unknown writeback data to x%0d", $sampled(i_wrAddr));

endmodule

// File: rtl/alu.sv
// ------------------------------------------------
// Shifts use operand B bits [4:0] only
// Compares return 0 or 1
// ------------------------------------------------
`timescale 1ns/1ps

module alu (
    input  rvCtrlPkg::aluOpT          i_aluOp,
    input  rvCtrlPkg::opBSelT         i_opBSel,
    input  logic [rvIsaPkg::XLEN-1:0] i_operandA,
    input  logic [rvIsaPkg::XLEN-1:0] i_regB,
    input  logic [rvIsaPkg::XLEN-1:0] i_imm,
    output logic [rvIsaPkg::XLEN-1:0] o_result
);

    logic [rvIsaPkg::XLEN-1:0]    operandB;
    logic [rvIsaPkg::SHAMT_W-1:0] shamt;
    logic                         ltSigned;
    logic                         ltUnsigned;

    assign operandB   = (i_opBSel == rvCtrlPkg::OPB_IMM) ? i_imm : i_regB;
    assign shamt      = operandB[rvIsaPkg::SHAMT_W-1:0];  // Upper bits ignored
    assign ltSigned   = $signed(i_operandA) < $signed(operandB);
    assign ltUnsigned = i_operandA < operandB;

    always_comb begin
        case (i_aluOp)
            rvCtrlPkg::ALU_ADD:   o_result = i_operandA + operandB;
            rvCtrlPkg::ALU_SUB:   o_result = i_operandA - operandB;
            rvCtrlPkg::ALU_AND:   o_result = i_operandA & operandB;
            rvCtrlPkg::ALU_OR:    o_result = i_operandA | operandB;
            rvCtrlPkg::ALU_XOR:   o_result = i_operandA ^ operandB;
            rvCtrlPkg::ALU_SLL:   o_result = i_operandA << shamt;
            rvCtrlPkg::ALU_SRL:   o_result = i_operandA >> shamt;
            rvCtrlPkg::ALU_SRA:   o_result = $signed(i_operandA) >>> shamt;
            rvCtrlPkg::ALU_SLT:   o_result = {{(rvIsaPkg::XLEN-1){1'b0}}, ltSigned};
            rvCtrlPkg::ALU_SLTU:  o_result = {{(rvIsaPkg::XLEN-1){1'b0}}, ltUnsigned};
            rvCtrlPkg::ALU_PASSB: o_result = operandB;  // LUI
            default:              o_result = '0;
        endcase
    end

endmodule

// File: rtl/branchCompare.sv
// ------------------------------------------------
// Branch condition from funct3, undefined codes
// 010 and 011 never take
// ------------------------------------------------
`timescale 1ns/1ps

module branchCompare (
    input  logic [rvIsaPkg::FUNCT3_W-1:0] i_funct3,
    input  logic [rvIsaPkg::XLEN-1:0]     i_operandA,
    input  logic [rvIsaPkg::XLEN-1:0]     i_operandB,
    output logic                          o_taken
);

    logic isEqual;
    logic ltSigned;
    logic ltUnsigned;

    assign isEqual    = i_operandA == i_operandB;
    assign ltSigned   = $signed(i_operandA) < $signed(i_operandB);
    assign ltUnsigned = i_operandA < i_operandB;

    always_comb begin
        case (i_funct3)
            rvIsaPkg::F3_BEQ:  o_taken = isEqual;
            rvIsaPkg::F3_BNE:  o_taken = !isEqual;
            rvIsaPkg::F3_BLT:  o_taken = ltSigned;
            rvIsaPkg::F3_BGE:  o_taken = !ltSigned;
            rvIsaPkg::F3_BLTU: o_taken = ltUnsigned;
            rvIsaPkg::F3_BGEU: o_taken = !ltUnsigned;
            default:           o_taken = 1'b0;
        endcase
    end

endmodule

// File: rtl/programCounter.sv
// ------------------------------------------------
// PC loads a new value on every edge
// Targets are assumed word aligned
// ------------------------------------------------
`timescale 1ns/1ps

module programCounter (
    input  logic                      i_Clock,
    input  logic                      i_rstN,
    input  logic [rvIsaPkg::XLEN-1:0] i_imm,
    input  logic                      i_isJump,
    input  logic                      i_isBranch,
    input  logic                      i_taken,
    output logic [rvIsaPkg::XLEN-1:0] o_pc,
    output logic [rvIsaPkg::XLEN-1:0] o_pcPlus4
);

    logic [rvIsaPkg::XLEN-1:0] pcTarget;
    logic [rvIsaPkg::XLEN-1:0] pcNext;
    logic                      redirect;

    assign o_pcPlus4 = o_pc + 32'd4;
    assign pcTarget  = o_pc + i_imm;  // Shared by branches and JAL
    assign redirect  = i_isJump || (i_isBranch && i_taken);
    assign pcNext    = redirect ? pcTarget : o_pcPlus4;

    always_ff @(posedge i_Clock) begin
        if (!i_rstN) begin
            o_pc <= rvIsaPkg::RESET_PC;
        end else begin
            o_pc <= pcNext;
        end
    end

    // A bad immediate would show up here first
    pcAligned: assert property (@(posedge i_Clock) disable iff (!i_rstN) o_pc[1:0] == 2'b00)
        else $error("Misaligned PC %h", o_pc);

endmodule

// File: rtl/cpuCore.sv
// ------------------------------------------------
// Single-cycle RV32I subset core, one instruction
// per clock, memories read combinationally
// ------------------------------------------------
`timescale 1ns/1ps

module cpuCore (
    input  logic                      i_Clock,
    input  logic                      i_rstN,
    output logic [rvIsaPkg::XLEN-1:0] o_pgmAddr,
    input  logic [rvIsaPkg::XLEN-1:0] i_pgmData,
    output logic [rvIsaPkg::XLEN-1:0] o_memAddr,
    output logic [rvIsaPkg::XLEN-1:0] o_memWrData,
    output logic                      o_memWrEnable,
    input  logic [rvIsaPkg::XLEN-1:0] i_memRdData
);

    logic [rvIsaPkg::REG_ADDR_W-1:0] rs1;
    logic [rvIsaPkg::REG_ADDR_W-1:0] rs2;
    logic [rvIsaPkg::REG_ADDR_W-1:0] rd;
    logic [rvIsaPkg::FUNCT3_W-1:0]   funct3;
    logic [rvIsaPkg::XLEN-1:0]       imm;
    logic [rvIsaPkg::XLEN-1:0]       rdDataA;
    logic [rvIsaPkg::XLEN-1:0]       pcPlus4;
    rvCtrlPkg::aluOpT                aluOp;
    rvCtrlPkg::opBSelT               opBSel;
    rvCtrlPkg::wbSelT                wbSel;
    logic                            regWrEnable;
    logic                            isBranch;
    logic                            isJump;
    logic                            taken;

    instDecoder dec (
        .i_inst   (i_pgmData),
        .o_rs1    (rs1),
        .o_rs2    (rs2),
        .o_rd     (rd),
        .o_funct3 (funct3),
        .o_imm    (imm)
    );

    controlUnit ctrl (
        .i_rstN        (i_rstN),
        .i_inst        (i_pgmData),
        .o_aluOp       (aluOp),
        .o_opBSel      (opBSel),
        .o_wbSel       (wbSel),
        .o_regWrEnable (regWrEnable),
        .o_memWrEnable (o_memWrEnable),
        .o_isBranch    (isBranch),
        .o_isJump      (isJump)
    );

    // Read port B doubles as the store data
    regFile regs (
        .i_Clock     (i_Clock),
        .i_rstN      (i_rstN),
        .i_rdAddrA   (rs1),
        .i_rdAddrB   (rs2),
        .i_wrAddr    (rd),
        .i_wrEnable  (regWrEnable),
        .i_wbSel     (wbSel),
        .i_aluResult (o_memAddr),
        .i_memRdData (i_memRdData),
        .i_pcPlus4   (pcPlus4),
        .o_rdDataA   (rdDataA),
        .o_rdDataB   (o_memWrData)
    );

    alu aluUnit (
        .i_aluOp    (aluOp),
        .i_opBSel   (opBSel),
        .i_operandA (rdDataA),
        .i_regB     (o_memWrData),
        .i_imm      (imm),
        .o_result   (o_memAddr)   // Also the load/store address
    );

    branchCompare cmp (
        .i_funct3   (funct3),
        .i_operandA (rdDataA),
        .i_operandB (o_memWrData),
        .o_taken    (taken)
    );

    programCounter pc (
        .i_Clock    (i_Clock),
        .i_rstN     (i_rstN),
        .i_imm      (imm),
        .i_isJump   (isJump),
        .i_isBranch (isBranch),
        .i_taken    (taken),
        .o_pc       (o_pgmAddr),
        .o_pcPlus4  (pcPlus4)
    );

endmodule

// File: verification/cpuCoreProgram.svh
// ------------------------------------------------
// Test program and expected store table, built at
// time zero after data memory is randomized
// ------------------------------------------------

// x1 = -16, x2 = 5, x3 = 35 are the shared operands
task automatic buildProgram;
    int jalPc;

    storeReg(5'd0, 32'd0);  // Fetched during reset, strobe must stay low

    emit(aluImmInst(3'b000, 5'd1, 5'd0, 12'hFF0));  // ADDI x1, x0, -16
    emit(aluImmInst(3'b000, 5'd2, 5'd0, 12'd5));
    emit(aluImmInst(3'b000, 5'd3, 5'd0, 12'd35));   // Shift amount 35 acts as 3

    checkOp(aluRegInst(7'b0000000, 3'b000, 5'd5, 5'd1, 5'd2), 32'hFFFF_FFF5);  // ADD
    checkOp(aluRegInst(7'b0100000, 3'b000, 5'd5, 5'd2, 5'd1), 32'h0000_0015);  // SUB
    checkOp(aluRegInst(7'b0000000, 3'b111, 5'd5, 5'd1, 5'd3), 32'h0000_0020);  // AND
    checkOp(aluRegInst(7'b0000000, 3'b110, 5'd5, 5'd1, 5'd2), 32'hFFFF_FFF5);  // OR
    checkOp(aluRegInst(7'b0000000, 3'b100, 5'd5, 5'd1, 5'd3), 32'hFFFF_FFD3);  // XOR
    checkOp(aluRegInst(7'b0000000, 3'b001, 5'd5, 5'd2, 5'd3), 32'h0000_0028);  // SLL
    checkOp(aluRegInst(7'b0000000, 3'b101, 5'd5, 5'd1, 5'd3), 32'h1FFF_FFFE);  // SRL
    checkOp(aluRegInst(7'b0100000, 3'b101, 5'd5, 5'd1, 5'd3), 32'hFFFF_FFFE);  // SRA
    checkOp(aluRegInst(7'b0000000, 3'b010, 5'd5, 5'd1, 5'd2), 32'h0000_0001);  // SLT
    checkOp(aluRegInst(7'b0000000, 3'b011, 5'd5, 5'd1, 5'd2), 32'h0000_0000);  // SLTU
    checkOp(aluImmInst(3'b000, 5'd5, 5'd1, 12'd100), 32'h0000_0054);           // ADDI
    checkOp(aluImmInst(3'b111, 5'd5, 5'd1, 12'h0FF), 32'h0000_00F0);           // ANDI
    checkOp(aluImmInst(3'b110, 5'd5, 5'd2, 12'hF00), 32'hFFFF_FF05);           // ORI
    checkOp(aluImmInst(3'b100, 5'd5, 5'd1, 12'h7FF), 32'hFFFF_F80F);           // XORI
    checkOp(aluImmInst(3'b010, 5'd5, 5'd1, 12'hFFF), 32'h0000_0001);           // SLTI
    checkOp({20'hABCDE, 5'd5, 7'b0110111}, 32'hABCD_E000);                     // LUI

    copyWord(12'h000);
    copyWord(12'h044);
    copyWord(12'h0FC);

    // Taken operands first, then not-taken operands
    branchPair(3'b000, 5'd2, 5'd2, 5'd1, 5'd2);  // BEQ
    branchPair(3'b001, 5'd1, 5'd2, 5'd2, 5'd2);  // BNE
    branchPair(3'b100, 5'd1, 5'd2, 5'd2, 5'd1);  // BLT
    branchPair(3'b101, 5'd2, 5'd1, 5'd1, 5'd2);  // BGE
    branchPair(3'b110, 5'd2, 5'd1, 5'd1, 5'd2);  // BLTU
    branchPair(3'b111, 5'd1, 5'd2, 5'd2, 5'd1);  // BGEU

    jalPc = 4 * pgmLen;
    emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd7, 7'b1101111});  // JAL x7, +8
    emit(storeInst(5'd0, 5'd0, WRONG_ADDR));
    storeReg(5'd7, 32'(jalPc + 4));

    emit(aluImmInst(3'b000, 5'd0, 5'd2, 12'd7));  // Write to x0 is dropped
    storeReg(5'd0, 32'd0);

    emit(storeInst(5'd0, 5'd0, SENTINEL_ADDR));
endtask

// File: verification/cpuCoreTb.sv
// ------------------------------------------------
// Self-checking core test, runs until a store to
// the sentinel address or until the watchdog fires
// ------------------------------------------------
`timescale 1ns/1ps

module cpuCoreTb;

    localparam int PERIOD     = 8;
    localparam int RST_CYCLES = 2;
    localparam logic [11:0] RESULT_BASE   = 12'h100;
    localparam logic [11:0] WRONG_ADDR    = 12'h3F8;  // Never written by a correct run
    localparam logic [11:0] SENTINEL_ADDR = 12'h3FC;

    logic        clock = 1'b0;
    logic        rstN  = 1'b0;
    logic [31:0] pgmAddr;
    logic [31:0] pgmData;
    logic [31:0] memAddr;
    logic [31:0] memWrData;
    logic        memWrEnable;
    logic [31:0] memRdData;

    logic [31:0] pgmMem  [128];
    logic [31:0] dataMem [256];
    logic [31:0] expAddr [64];
    logic [31:0] expData [64];
    int          pgmLen   = 0;
    int          expCount = 0;
    int          storeIdx = 0;  // Next expected store
    int          errors   = 0;

    cpuCore UUT (
        .i_Clock       (clock),
        .i_rstN        (rstN),
        .o_pgmAddr     (pgmAddr),
        .i_pgmData     (pgmData),
        .o_memAddr     (memAddr),
        .o_memWrData   (memWrData),
        .o_memWrEnable (memWrEnable),
        .i_memRdData   (memRdData)
    );

    always #(PERIOD / 2) clock = ~clock;

    // Both memories read combinationally
    assign pgmData   = pgmMem[pgmAddr[8:2]];
    assign memRdData = dataMem[memAddr[9:2]];

    always @(posedge clock) begin
        if (memWrEnable) begin
            dataMem[memAddr[9:2]] <= memWrData;
        end
    end

    function automatic logic [31:0] aluRegInst(input logic [6:0] f7, input logic [2:0] f3,
                                               input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] aluImmInst(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                               input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] storeInst(input logic [4:0] rs2, rs1,
                                              input logic [11:0] off);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branchInst(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                               input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic emit(input logic [31:0] word);
        pgmMem[pgmLen] = word;
        pgmLen++;
    endtask

    // SW to the next result slot, logged as the next expected bus store
    task automatic storeReg(input logic [4:0] rs2, input logic [31:0] value);
        logic [11:0] slot;
        slot = RESULT_BASE + 12'(4 * expCount);
        emit(storeInst(rs2, 5'd0, slot));
        expAddr[expCount] = {20'd0, slot};
        expData[expCount] = value;
        expCount++;
    endtask

    task automatic checkOp(input logic [31:0] word, input logic [31:0] value);
        emit(word);
        storeReg(5'd5, value);
    endtask

    task automatic copyWord(input logic [11:0] src);
        emit({src, 5'd0, 3'b010, 5'd6, 7'b0000011});  // LW x6, src(x0)
        storeReg(5'd6, dataMem[src[9:2]]);
    endtask

    // Taken branch skips a wrong-path store, the not-taken one falls into a marker
    task automatic branchPair(input logic [2:0] f3, input logic [4:0] rs1T, rs2T, rs1N, rs2N);
        emit(branchInst(f3, rs1T, rs2T, 13'd8));
        emit(storeInst(5'd0, 5'd0, WRONG_ADDR));
        emit(branchInst(f3, rs1N, rs2N, 13'd8));
        storeReg(5'd2, 32'd5);
    endtask

    task automatic reportError(input string msg);
        errors++;
        $display("Error: %0t %s", $time, msg);
    endtask

    `include "cpuCoreProgram.svh"

    noStoreInReset: assert property (@(posedge clock) !rstN |-> !memWrEnable)
        else reportError("store strobe while in reset");

    fetchFromZero: assert property (@(posedge clock) $rose(rstN) |-> pgmAddr == 32'h0)
        else reportError($sformatf("first fetch at %h", $sampled(pgmAddr)));

    storeMatches: assert property (@(posedge clock) disable iff (!rstN)
            memWrEnable && memAddr < WRONG_ADDR
            |-> memAddr == expAddr[storeIdx] && memWrData == expData[storeIdx])
        else reportError($sformatf("store %0d wrote %h to %h, expected %h to %h",
            $sampled(storeIdx), $sampled(memWrData), $sampled(memAddr),
            expData[$sampled(storeIdx)], expAddr[$sampled(storeIdx)]));

    noWrongPath: assert property (@(posedge clock) disable iff (!rstN)
            !(memWrEnable && memAddr == WRONG_ADDR))
        else reportError("store on a wrong branch or jump path");

    always @(posedge clock) begin
        if (rstN && memWrEnable && memAddr < WRONG_ADDR) begin
            storeIdx <= storeIdx + 1;
        end
    end

    initial begin
        void'($urandom(32'heab3));
        for (int i = 0; i < 256; i++) begin
            dataMem[i] = $urandom();
        end
        buildProgram();
        repeat (RST_CYCLES) @(posedge clock);
        #1 rstN = 1'b1;
        @(negedge clock);
        while (!(memWrEnable && memAddr == SENTINEL_ADDR)) @(negedge clock);
        if (storeIdx != expCount) begin
            errors++;
            $display("Program ended after %0d of %0d expected stores", storeIdx, expCount);
        end
        $display("Stores checked: %0d of %0d, errors: %0d", storeIdx, expCount, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Straight-line program, four times its length is ample
    initial begin
        #1;
        repeat (RST_CYCLES + 4 * pgmLen) @(posedge clock);
        $display("Timeout, no sentinel store after %0d cycles", RST_CYCLES + 4 * pgmLen);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+verification
rtl/rvIsaPkg.sv
rtl/rvCtrlPkg.sv
rtl/instDecoder.sv
rtl/controlUnit.sv
rtl/regFile.sv
rtl/alu.sv
rtl/branchCompare.sv
rtl/programCounter.sv
rtl/cpuCore.sv
verification/cpuCoreTb.sv
